// ==== common/phy_mem_pkg.sv ====
// Physical memory controller shared definitions.
// Widths, the 8 MiB address window and the state and bank encodings
// used by the request latch, the controller and the bank driver.

package phy_mem_pkg;

	// cpu side data and address words.
	localparam int data_width = 32;
	localparam int addr_width = 32;

	// one sram bank holds 2^20 words.
	localparam int ram_addr_width = 20;

	// bank bit plus bank word address, byte address bits 22 down to 2.
	localparam int word_addr_width = ram_addr_width + 1;

	// byte offset bits below the word address.
	localparam int addr_lsb = 2;

	// addresses that survive this mask fall in the 8 MiB sram window.
	localparam logic [addr_width-1:0] ram_addr_mask = 32'h007f_ffff;

	// recovery wait input and counter width.
	localparam int wait_width = 8;

	// bank chosen by the top bit of the word address.
	typedef enum logic {
		bank_base = 1'b0,
		bank_ext = 1'b1
	} bank_sel_t;

	// Write sequencing states. The two write states differ in one bit so
	// that we_n only toggles between st_write0 and st_write1.
	typedef enum logic [1:0] {
		st_read = 2'b00,
		st_write0 = 2'b01,
		st_write1 = 2'b11,
		st_recover = 2'b10
	} ctrl_state_t;

endpackage

// ==== common/mem_req_if.sv ====
// Request path between the cpu input side and the write controller.
// Carries the latched write, the live read address and the idle level
// fed back from the controller.

interface mem_req_if;
	import phy_mem_pkg::*;

	logic write_req;	// one cycle pulse per accepted write.
	logic [addr_width-1:0] write_addr;	// held until the next accepted write.
	logic [data_width-1:0] write_data;
	logic [addr_width-1:0] read_addr;	// live cpu address.
	logic idle;	// controller sits in st_read.

	modport req (
		output write_req, write_addr, write_data, read_addr,
		input idle
	);

	modport ctrl (
		input write_req, write_addr, write_data, read_addr,
		output idle
	);

endinterface

// ==== common/ram_bus_if.sv ====
// Decoded sram bus between the write controller and the bank driver.
// Enables are shared here and split onto the two banks downstream.
// The clock is carried only so the bank side can sample its checks.

interface ram_bus_if (
	input logic clk
);
	import phy_mem_pkg::*;

	logic [word_addr_width-1:0] word_addr;	// bank bit on top.
	logic oe_n;	// active low output enable.
	logic we_n;	// active low write enable.
	logic [data_width-1:0] wdata;	// latched write data.
	logic [data_width-1:0] rdata;	// data of the selected bank.

	modport ctrl (
		input clk,
		output word_addr, oe_n, we_n, wdata,
		input rdata
	);

	modport bank (
		input clk,
		input word_addr, oe_n, we_n, wdata,
		output rdata
	);

endinterface

// ==== source/mem_req_latch.sv ====
// Input side of the memory controller.
// Range checks cpu writes, latches accepted ones on the falling edge
// and reports busy back to the cpu.

module mem_req_latch (
	input logic clk,
	input logic rst,
	input logic is_write,
	input logic [phy_mem_pkg::addr_width-1:0] addr,
	input logic [phy_mem_pkg::data_width-1:0] data_in,
	output logic busy,
	output logic range_fault,
	mem_req_if.req req
);
	import phy_mem_pkg::*;

	logic accept;
	logic in_range;

	// only a strobe seen while nothing is pending starts a write.
	assign accept = is_write && req.idle && !req.write_req;
	assign in_range = (addr & ram_addr_mask) == addr;

	always_ff @(negedge clk) begin
		if (rst) begin
			req.write_req <= 1'b0;
			range_fault <= 1'b0;
		end else begin
			req.write_req <= accept && in_range;
			range_fault <= accept && !in_range;	// dropped write.
		end
	end

	always_ff @(negedge clk) begin
		if (accept && in_range) begin
			req.write_addr <= addr;
			req.write_data <= data_in;
		end
	end

	assign req.read_addr = addr;	// reads go straight through.

	// Busy covers the strobe cycle itself, the pending request and the
	// whole write sequence in the controller.
	assign busy = is_write || req.write_req || !req.idle;

	// Misaligned accesses are only reported.
	addr_aligned: assert property (@(negedge clk) disable iff (rst)
		(is_write || !busy) |-> (addr[addr_lsb-1:0] == '0))
		else $warning("unaligned access to %h", addr);

	single_strobe: assert property (@(negedge clk) disable iff (rst)
		is_write |=> !is_write)
		else $error("is_write held for more than one cycle");

	// a strobe during a running write would be silently lost.
	strobe_when_idle: assert property (@(negedge clk) disable iff (rst)
		is_write |-> (req.idle && !req.write_req))
		else $error("is_write while controller busy");

endmodule

// ==== phy_mem_ctrl/phy_mem_ctrl.sv ====
// Write sequencing for the sram banks.
// A latched write moves the controller through two enable steps and a
// programmable recovery wait before reads resume. Runs on the falling
// clock edge so the sram controls change mid cycle.

module phy_mem_ctrl (
	input logic clk,
	input logic rst,
	input logic [phy_mem_pkg::wait_width-1:0] ram_read_wait,
	mem_req_if.ctrl req,
	ram_bus_if.ctrl ram
);
	import phy_mem_pkg::*;

	localparam int addr_msb = word_addr_width + addr_lsb - 1;

	ctrl_state_t state;
	logic [wait_width-1:0] wait_cnt;
	logic reading;

	always_ff @(negedge clk) begin
		if (rst) begin
			state <= st_read;
			wait_cnt <= '0;
		end else begin
			case (state)
				st_read: begin
					if (req.write_req) begin
						state <= st_write0;	// oe goes high, data is driven.
					end
				end
				st_write0: begin
					state <= st_write1;	// data has settled, pulse we.
				end
				st_write1: begin
					wait_cnt <= '0;
					state <= st_recover;
				end
				st_recover: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == ram_read_wait) begin
						state <= st_read;	// ram_read_wait+1 cycles spent here.
					end
				end
				default: begin
					state <= st_read;
				end
			endcase
		end
	end

	// The bank output is enabled again during recovery so the read data
	// has time to settle before the cpu is released.
	assign reading = (state == st_read) || (state == st_recover);

	assign ram.oe_n = !reading;
	assign ram.we_n = (state != st_write1);

	assign ram.word_addr = reading ? req.read_addr[addr_msb:addr_lsb]
		: req.write_addr[addr_msb:addr_lsb];
	assign ram.wdata = req.write_data;

	assign req.idle = (state == st_read);

	// Write data must be on the bus a full cycle before we falls, and
	// the banks must never drive while being written.
	we_after_oe: assert property (@(negedge clk) disable iff (rst)
		!ram.we_n |-> (ram.oe_n && $past(ram.oe_n)))
		else $error("we_n low without oe_n high in the previous cycle");

	// every write request gets a full sequence from st_read.
	req_only_idle: assert property (@(negedge clk) disable iff (rst)
		req.write_req |-> (state == st_read))
		else $error("write request while the sequencer was busy");

endmodule

// ==== source/sram_bank_mux.sv ====
// Output side of the memory controller.
// Splits the shared enables onto the selected sram bank, drives the
// write data onto the bank buses and returns the selected bank's data.

module sram_bank_mux (
	ram_bus_if.bank ram,
	output logic [phy_mem_pkg::ram_addr_width-1:0] base_addr,
	inout wire [phy_mem_pkg::data_width-1:0] base_data,
	output logic base_ce,
	output logic base_oe,
	output logic base_we,
	output logic [phy_mem_pkg::ram_addr_width-1:0] ext_addr,
	inout wire [phy_mem_pkg::data_width-1:0] ext_data,
	output logic ext_ce,
	output logic ext_oe,
	output logic ext_we
);
	import phy_mem_pkg::*;

	bank_sel_t bank_sel;

	assign bank_sel = bank_sel_t'(ram.word_addr[ram_addr_width]);

	// Both banks share the word address, only chip enables differ.
	assign base_addr = ram.word_addr[ram_addr_width-1:0];
	assign ext_addr = ram.word_addr[ram_addr_width-1:0];

	assign base_ce = (bank_sel != bank_base);	// active low.
	assign ext_ce = (bank_sel != bank_ext);

	// a deselected bank keeps its strobes high.
	assign base_oe = base_ce || ram.oe_n;
	assign base_we = base_ce || ram.we_n;
	assign ext_oe = ext_ce || ram.oe_n;
	assign ext_we = ext_ce || ram.we_n;

	// Write data goes out as soon as oe is released, so it is stable
	// before the write enable pulse.
	assign base_data = base_oe ? ram.wdata : {data_width{1'bz}};
	assign ext_data = ext_oe ? ram.wdata : {data_width{1'bz}};

	assign ram.rdata = (bank_sel == bank_ext) ? ext_data : base_data;

	// never two banks active on the shared address at once.
	one_bank_active: assert property (@(negedge ram.clk)
		!((!base_oe || !base_we) && (!ext_oe || !ext_we)))
		else $error("both sram banks enabled together");

endmodule

// ==== source/phy_mem_top.sv ====
// Physical memory controller top level.
// Connects the request latch, the write sequencer and the sram bank
// driver for the base and ext asynchronous sram banks.

module phy_mem_top (
	input logic clk,
	input logic rst,
	input logic is_write,
	input logic [phy_mem_pkg::addr_width-1:0] addr,
	input logic [phy_mem_pkg::data_width-1:0] data_in,
	output logic [phy_mem_pkg::data_width-1:0] data_out,
	output logic busy,
	output logic range_fault,
	input logic [phy_mem_pkg::wait_width-1:0] ram_read_wait,
	output logic [phy_mem_pkg::ram_addr_width-1:0] base_addr,
	inout wire [phy_mem_pkg::data_width-1:0] base_data,
	output logic base_ce,
	output logic base_oe,
	output logic base_we,
	output logic [phy_mem_pkg::ram_addr_width-1:0] ext_addr,
	inout wire [phy_mem_pkg::data_width-1:0] ext_data,
	output logic ext_ce,
	output logic ext_oe,
	output logic ext_we
);

	mem_req_if req_bus ();
	ram_bus_if ram_bus (.clk(clk));

	mem_req_latch u_req_latch (
		.clk(clk),
		.rst(rst),
		.is_write(is_write),
		.addr(addr),
		.data_in(data_in),
		.busy(busy),
		.range_fault(range_fault),
		.req(req_bus.req)
	);

	phy_mem_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.ram_read_wait(ram_read_wait),
		.req(req_bus.ctrl),
		.ram(ram_bus.ctrl)
	);

	sram_bank_mux u_bank_mux (
		.ram(ram_bus.bank),
		.base_addr(base_addr),
		.base_data(base_data),
		.base_ce(base_ce),
		.base_oe(base_oe),
		.base_we(base_we),
		.ext_addr(ext_addr),
		.ext_data(ext_data),
		.ext_ce(ext_ce),
		.ext_oe(ext_oe),
		.ext_we(ext_we)
	);

	assign data_out = ram_bus.rdata;	// reads pass through in the same cycle.

endmodule

// ==== tb/sram_model.sv ====
// Behavioral asynchronous sram bank with active low strobes.
// Unwritten words read as their index xor a per bank key.

module sram_model #(
	parameter logic [31:0] fill_key = 32'h0
) (
	input logic [19:0] addr,
	inout wire [31:0] data,
	input logic ce,
	input logic oe,
	input logic we
);
	localparam int depth = 1 << 20;

	logic [31:0] mem [depth];

	// The bank drives its data only while selected and output enabled.
	assign data = (!ce && !oe) ? mem[addr] : {32{1'bz}};

	initial begin
		int i;
		for (i = 0; i < depth; i++) begin
			mem[i] = 32'(i) ^ fill_key;	// whole index goes into the pattern.
		end
		forever begin
			@(negedge we);
			#1;	// zero width glitches on we do not store anything.
			if (!we && !ce) begin
				mem[addr] = data;
			end
		end
	end

endmodule

// ==== tb/phy_mem_tb.sv ====
// Testbench for the physical memory controller.
// Runs directed and random reads and writes on two sram bank models and
// checks data, busy length and range faults against a reference memory.

module phy_mem_tb;
	localparam int drive_delay = 10;
	localparam int random_ops = 200;
	localparam int cycle_limit = 2000 + 300 * random_ops;
	localparam int busy_limit = 300;
	localparam logic [31:0] base_fill = 32'ha5c0_0000;
	localparam logic [31:0] ext_fill = 32'h3e10_0000;
	localparam logic [31:0] window_end = 32'h0080_0000;	// first byte past the sram window.
	localparam logic [7:0] wait_list [4] = '{8'd0, 8'd1, 8'd5, 8'd17};

	typedef enum logic [1:0] {
		op_read,
		op_write,
		op_end
	} op_kind_t;

	// One observed bus operation, handed from the stimulus to the checker.
	typedef struct {
		op_kind_t kind;
		logic [31:0] addr;
		logic [31:0] data;
		logic [7:0] wait_cycles;
		int edges;
		logic fault_first;
		logic fault_second;
		logic busy_seen;
		time at;
	} obs_t;

	logic clk;
	logic rst;
	logic is_write;
	logic [31:0] addr;
	logic [31:0] data_in;
	logic [31:0] data_out;
	logic busy;
	logic range_fault;
	logic [7:0] ram_read_wait;
	logic [19:0] base_addr;
	wire [31:0] base_data;
	logic base_ce;
	logic base_oe;
	logic base_we;
	logic [19:0] ext_addr;
	wire [31:0] ext_data;
	logic ext_ce;
	logic ext_oe;
	logic ext_we;

	obs_t obs_q[$];
	string test_names[$];
	logic [31:0] lfsr;
	logic stim_done;
	int cycle_count;
	logic [31:0] ref_mem [logic [20:0]];	// written words by bank bit and word address.

	phy_mem_top DUT (
		.clk(clk),
		.rst(rst),
		.is_write(is_write),
		.addr(addr),
		.data_in(data_in),
		.data_out(data_out),
		.busy(busy),
		.range_fault(range_fault),
		.ram_read_wait(ram_read_wait),
		.base_addr(base_addr),
		.base_data(base_data),
		.base_ce(base_ce),
		.base_oe(base_oe),
		.base_we(base_we),
		.ext_addr(ext_addr),
		.ext_data(ext_data),
		.ext_ce(ext_ce),
		.ext_oe(ext_oe),
		.ext_we(ext_we)
	);

	sram_model #(.fill_key(base_fill)) base_bank (
		.addr(base_addr),
		.data(base_data),
		.ce(base_ce),
		.oe(base_oe),
		.we(base_we)
	);

	sram_model #(.fill_key(ext_fill)) ext_bank (
		.addr(ext_addr),
		.data(ext_data),
		.ce(ext_ce),
		.oe(ext_oe),
		.we(ext_we)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// the lfsr advances once for every bit handed out.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic logic [31:0] expected_read(input logic [31:0] a);
		logic [20:0] word;
		word = a[22:2];
		if (ref_mem.exists(word)) begin
			return ref_mem[word];
		end
		return {12'h0, word[19:0]} ^ (word[20] ? ext_fill : base_fill);
	endfunction

	// Falling edges from the strobe sample until busy is seen low again.
	function automatic int expected_busy_edges(input logic [31:0] a, input logic [7:0] w);
		if (a < window_end) begin
			return int'(w) + 4;
		end
		return 1;
	endfunction

	task automatic do_read(input logic [31:0] a);
		obs_t o;
		addr = a;
		is_write = 1'b0;
		@(posedge clk);
		o.kind = op_read;
		o.addr = a;
		o.data = data_out;	// settled half a cycle after the last falling edge.
		o.busy_seen = busy;
		o.at = $time;
		obs_q.push_back(o);
		#drive_delay;
	endtask

	task automatic do_write(input logic [31:0] a, input logic [31:0] d, input logic [7:0] w);
		obs_t o;
		addr = a;
		data_in = d;
		ram_read_wait = w;
		is_write = 1'b1;
		@(negedge clk);	// this edge samples the strobe.
		@(posedge clk);
		o.fault_first = range_fault;
		o.fault_second = 1'b0;
		o.edges = 0;
		#drive_delay;
		is_write = 1'b0;
		addr = a ^ 32'h0040_0004;	// the sequencer must work from its latched copies now.
		data_in = ~d;
		do begin
			@(negedge clk);
			o.edges++;
			@(posedge clk);
			if (o.edges == 1) begin
				o.fault_second = range_fault;
			end
		end while (busy && o.edges < busy_limit);
		o.kind = op_write;
		o.addr = a;
		o.data = d;
		o.wait_cycles = w;
		o.at = $time;
		obs_q.push_back(o);
		#drive_delay;
	endtask

	task automatic end_test(input string name);
		obs_t o;
		o.kind = op_end;
		o.at = $time;
		test_names.push_back(name);
		obs_q.push_back(o);
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] r_op;
		logic [31:0] r_bank;
		logic [31:0] r_hi;
		logic [31:0] r_lo;
		logic [31:0] r_data;
		logic [31:0] r_wait;
		logic [20:0] word;
		int k;
		int n;
		rst = 1'b1;
		is_write = 1'b0;
		addr = '0;
		data_in = '0;
		ram_read_wait = '0;
		lfsr = 32'hd4f;
		stim_done = 1'b0;
		repeat (10) @(posedge clk);
		#drive_delay;
		rst = 1'b0;

		do_read(32'h0000_0000);
		do_read(32'h0000_0004);
		do_read(32'h003f_fffc);
		do_read(32'h0040_0000);
		do_read(32'h0045_6788);
		do_read(32'h007f_fffc);
		end_test("reset_fill");

		do_write(32'h0001_2340, 32'hcafe_0001, 8'd2);
		do_read(32'h0001_2340);
		do_read(32'h0041_2340);	// same offset in the other bank.
		do_write(32'h0055_5550, 32'h1234_5678, 8'd0);
		do_read(32'h0055_5550);
		do_read(32'h0015_5550);
		end_test("write_read");

		for (k = 0; k < 4; k++) begin
			a = (k % 2 == 1) ? 32'h0060_0100 : 32'h0020_0100;
			a = a + 32'(k) * 4;
			do_write(a, 32'h7700_0000 + 32'(k), wait_list[k]);
			do_read(a);
		end
		end_test("recovery_wait");

		do_write(32'h0080_0010, 32'hdead_beef, 8'd3);
		do_read(32'h0000_0010);	// aliased target word must be unchanged.
		do_write(32'hf100_0040, 32'h0bad_f00d, 8'd1);
		do_read(32'h0000_0040);
		end_test("range_fault");

		// A narrow address set so that reads often hit earlier writes.
		for (n = 0; n < random_ops; n++) begin
			r_op = take_bits(1);
			r_bank = take_bits(1);
			r_hi = take_bits(4);
			r_lo = take_bits(4);
			r_data = take_bits(32);
			r_wait = take_bits(3);
			word = {r_bank[0], r_hi[3:0], 12'h0, r_lo[3:0]};
			a = {9'h0, word, 2'b00};
			if (r_op[0]) begin
				do_write(a, r_data, r_wait[7:0]);
			end else begin
				do_read(a);
			end
		end
		end_test("random");
		stim_done = 1'b1;
	end

	initial begin
		obs_t o;
		logic [31:0] exp_data;
		int exp_edges;
		int test_checks;
		int test_errors;
		int total_checks;
		int total_errors;
		int tests;
		test_checks = 0;
		test_errors = 0;
		total_checks = 0;
		total_errors = 0;
		tests = 0;
		while (!(stim_done && obs_q.size() == 0)) begin
			@(posedge clk);
			while (obs_q.size() > 0) begin
				o = obs_q.pop_front();
				case (o.kind)
					op_read: begin
						exp_data = expected_read(o.addr);
						test_checks += 2;
						assert (o.data === exp_data) else begin
							test_errors++;
							$display("error at %0t: read of %h returned %h, expected %h",
								o.at, o.addr, o.data, exp_data);
						end
						assert (o.busy_seen === 1'b0) else begin
							test_errors++;
							$display("error at %0t: busy high during read of %h", o.at, o.addr);
						end
					end
					op_write: begin
						exp_edges = expected_busy_edges(o.addr, o.wait_cycles);
						test_checks += 3;
						assert (o.edges == exp_edges) else begin
							test_errors++;
							$display("error at %0t: write to %h wait %0d busy for %0d edges, expected %0d",
								o.at, o.addr, o.wait_cycles, o.edges, exp_edges);
						end
						assert (o.fault_first === (o.addr >= window_end)) else begin
							test_errors++;
							$display("error at %0t: write to %h gave range_fault %b",
								o.at, o.addr, o.fault_first);
						end
						assert (o.fault_second === 1'b0) else begin
							test_errors++;
							$display("error at %0t: range_fault longer than one cycle for %h",
								o.at, o.addr);
						end
						if (o.addr < window_end) begin
							ref_mem[o.addr[22:2]] = o.data;
						end
					end
					default: begin
						$display("test %s: %0d checks, %0d errors", test_names.pop_front(),
							test_checks, test_errors);
						total_checks += test_checks;
						total_errors += test_errors;
						tests++;
						test_checks = 0;
						test_errors = 0;
					end
				endcase
			end
		end
		$display("%0d tests, %0d checks, %0d errors", tests, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== phy_mem.f ====
common/phy_mem_pkg.sv
common/mem_req_if.sv
common/ram_bus_if.sv
source/mem_req_latch.sv
phy_mem_ctrl/phy_mem_ctrl.sv
source/sram_bank_mux.sv
source/phy_mem_top.sv
tb/sram_model.sv
tb/phy_mem_tb.sv

// ==== Makefile ====
# Verilator build and run for the physical memory controller testbench.

VERILATOR ?= verilator
TOP ?= phy_mem_tb
FILELIST ?= phy_mem.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
PASS_TEXT ?= No errors

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard common/*.sv source/*.sv phy_mem_ctrl/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
